// File: csr_decode.sv
// SYSTEM instruction decoder

module csr_decode import rv_csr_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  csr_issue_t i_issue,
  output csr_req_t   o_req
);

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [4:0]            rs1_zimm;
  logic [CSR_ADDR_W-1:0] csr_addr;
  logic                  addr_ok;
  csr_sel_e              sel_d;
  csr_op_e               op_d;
  logic [XLEN-1:0]       operand_d;

  logic                  valid_q;
  csr_op_e               op_q;
  csr_sel_e              sel_q;
  logic [XLEN-1:0]       operand_q;
  logic [4:0]            rd_q;
  logic [XLEN-1:0]       pc_q;

  assign opcode   = i_issue.instr[6:0];
  assign funct3   = i_issue.instr[14:12];
  assign rs1_zimm = i_issue.instr[19:15];
  assign csr_addr = i_issue.instr[31:20];

  always_comb begin
    addr_ok = 1'b1;
    case (csr_addr)
      CSR_MSTATUS: sel_d = SEL_MSTATUS;
      CSR_MTVEC:   sel_d = SEL_MTVEC;
      CSR_MEPC:    sel_d = SEL_MEPC;
      CSR_MCAUSE:  sel_d = SEL_MCAUSE;
      default: begin
        sel_d   = SEL_MSTATUS;
        addr_ok = 1'b0;
      end
    endcase
  end

  always_comb begin
    op_d      = OP_ILLEGAL;
    operand_d = funct3[2] ? {{(XLEN-5){1'b0}}, rs1_zimm} : i_issue.rs1_val;
    if (!i_issue.valid) begin
      op_d = OP_NONE;
    end else if (opcode == OPC_SYSTEM) begin
      case (funct3)
        3'd1, 3'd5: op_d = OP_RW;
        3'd2, 3'd6: op_d = OP_RS;
        3'd3, 3'd7: op_d = OP_RC;
        3'd0: begin
          if (csr_addr == FUNCT12_ECALL) begin
            op_d = OP_ECALL;
          end else if (csr_addr == FUNCT12_MRET) begin
            op_d = OP_MRET;
          end
        end
        default: op_d = OP_ILLEGAL;
      endcase
      // Unimplemented CSRs trap here, so later stages never look at addresses.
      if (funct3[1:0] != 2'b00 && !addr_ok) begin
        op_d = OP_ILLEGAL;
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_issue.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    op_q      <= op_d;
    sel_q     <= sel_d;
    operand_q <= operand_d;
    rd_q      <= i_issue.instr[11:7];
    pc_q      <= i_issue.pc;
  end

  always_comb begin
    o_req.valid   = valid_q;
    o_req.op      = op_q;
    o_req.sel     = sel_q;
    o_req.operand = operand_q;
    o_req.rd      = rd_q;
    o_req.pc      = pc_q;
  end

endmodule

// File: csr_regfile.sv
// Machine-mode CSR file

module csr_regfile import rv_csr_pkg::*; (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  csr_req_t        i_req,
  input  trap_upd_t       i_trap,
  input  logic            i_redirect,
  input  logic [XLEN-1:0] i_redirect_pc,
  output logic [XLEN-1:0] o_mtvec,
  output logic [XLEN-1:0] o_mepc,
  output csr_rsp_t        o_rsp
);

  logic [XLEN-1:0] csr_q [4];
  logic [XLEN-1:0] old_val;
  logic [XLEN-1:0] new_val;
  logic            is_rmw;
  logic            wr_en;

  logic            rsp_valid_q;
  logic            rsp_rd_we_q;
  logic            rsp_redirect_q;
  logic [4:0]      rsp_rd_q;
  logic [XLEN-1:0] rsp_rdata_q;
  logic [XLEN-1:0] rsp_redirect_pc_q;

  assign old_val = csr_q[i_req.sel];
  assign o_mtvec = csr_q[SEL_MTVEC];
  assign o_mepc  = csr_q[SEL_MEPC];

  always_comb begin
    is_rmw  = 1'b0;
    wr_en   = 1'b0;
    new_val = old_val;
    case (i_req.op)
      OP_RW: begin
        is_rmw  = i_req.valid;
        wr_en   = i_req.valid;
        new_val = i_req.operand;
      end
      OP_RS: begin
        is_rmw  = i_req.valid;
        wr_en   = i_req.valid && (i_req.operand != '0);
        new_val = old_val | i_req.operand;
      end
      OP_RC: begin
        is_rmw  = i_req.valid;
        wr_en   = i_req.valid && (i_req.operand != '0);
        new_val = old_val & ~i_req.operand;
      end
      default: begin
        is_rmw = 1'b0;
        wr_en  = 1'b0;
      end
    endcase
    // mepc is always word aligned.
    if (i_req.sel == SEL_MEPC) begin
      new_val[1:0] = 2'b00;
    end
  end

  // The op decides whether a trap update or a CSR write runs.
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      csr_q[SEL_MSTATUS] <= MSTATUS_RESET;
      csr_q[SEL_MTVEC]   <= '0;
      csr_q[SEL_MEPC]    <= '0;
      csr_q[SEL_MCAUSE]  <= '0;
    end else if (i_trap.take) begin
      csr_q[SEL_MEPC]                       <= {i_trap.epc[XLEN-1:2], 2'b00};
      csr_q[SEL_MCAUSE]                     <= i_trap.cause;
      csr_q[SEL_MSTATUS][MSTATUS_MPIE_BIT] <= csr_q[SEL_MSTATUS][MSTATUS_MIE_BIT];
      csr_q[SEL_MSTATUS][MSTATUS_MIE_BIT]  <= 1'b0;
    end else if (i_trap.ret) begin
      csr_q[SEL_MSTATUS][MSTATUS_MIE_BIT]  <= csr_q[SEL_MSTATUS][MSTATUS_MPIE_BIT];
      csr_q[SEL_MSTATUS][MSTATUS_MPIE_BIT] <= 1'b1;
    end else if (wr_en) begin
      csr_q[i_req.sel] <= new_val;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rsp_valid_q    <= 1'b0;
      rsp_rd_we_q    <= 1'b0;
      rsp_redirect_q <= 1'b0;
    end else begin
      rsp_valid_q    <= i_req.valid;
      rsp_rd_we_q    <= is_rmw;
      rsp_redirect_q <= i_redirect;
    end
  end

  always_ff @(posedge i_clk) begin
    rsp_rd_q          <= i_req.rd;
    rsp_rdata_q       <= old_val;
    rsp_redirect_pc_q <= i_redirect_pc;
  end

  always_comb begin
    o_rsp.valid       = rsp_valid_q;
    o_rsp.rd_we       = rsp_rd_we_q;
    o_rsp.rd          = rsp_rd_q;
    o_rsp.rdata       = rsp_rdata_q;
    o_rsp.redirect    = rsp_redirect_q;
    o_rsp.redirect_pc = rsp_redirect_pc_q;
  end

endmodule

// File: csr_unit_sva.sv
// CSR unit protocol assertions

module csr_unit_sva import rv_csr_pkg::*; (
  input logic       i_clk,
  input logic       i_rst_n,
  input csr_issue_t i_issue,
  input csr_rsp_t   i_rsp
);
  timeunit 1ns;
  timeprecision 1ps;

  // Fixed two-cycle latency from issue to response.
  a_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_rsp.valid == $past(i_issue.valid, 2))
    else $error("response valid does not follow issue valid by two cycles");

  a_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_rsp.redirect && i_rsp.rd_we))
    else $error("redirect and rd_we set in the same response");

  a_redir_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_rsp.redirect |-> i_rsp.valid)
    else $error("redirect without a valid response");

  a_reset: assert property (@(posedge i_clk)
    !i_rst_n |-> (!i_rsp.valid && !i_rsp.rd_we && !i_rsp.redirect))
    else $error("response outputs active during reset");

endmodule

bind csr_unit_top csr_unit_sva u_sva (
  .i_clk   (i_clk),
  .i_rst_n (i_rst_n),
  .i_issue (i_issue),
  .i_rsp   (o_rsp)
);

// File: csr_unit_top.sv
// CSR and trap unit top

module csr_unit_top import rv_csr_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  csr_issue_t i_issue,
  output csr_rsp_t   o_rsp
);

  csr_req_t        req;
  trap_upd_t       trap;
  logic            redirect;
  logic [XLEN-1:0] redirect_pc;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;

  csr_decode u_decode (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_issue (i_issue),
    .o_req   (req)
  );

  // Trap control feeds the register file in the same cycle of the second stage.
  trap_unit u_trap (
    .i_req         (req),
    .i_mtvec       (mtvec),
    .i_mepc        (mepc),
    .o_trap        (trap),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc)
  );

  csr_regfile u_regfile (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_req         (req),
    .i_trap        (trap),
    .i_redirect    (redirect),
    .i_redirect_pc (redirect_pc),
    .o_mtvec       (mtvec),
    .o_mepc        (mepc),
    .o_rsp         (o_rsp)
  );

endmodule

// File: rv_csr_pkg.sv
// RV64 CSR unit definitions

package rv_csr_pkg;

  localparam int XLEN       = 64;
  localparam int CSR_ADDR_W = 12;

  // Implemented machine-mode CSR addresses.
  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;

  // SXL and UXL set to 64 bits, MPP set to M.
  localparam logic [XLEN-1:0] MSTATUS_RESET = 64'h0000_000a_0000_1800;

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;

  localparam logic [XLEN-1:0] CAUSE_ILLEGAL = 64'd2;
  localparam logic [XLEN-1:0] CAUSE_ECALL_M = 64'd11;

  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // imm12 values of the funct3 == 0 SYSTEM encodings.
  localparam logic [CSR_ADDR_W-1:0] FUNCT12_ECALL = 12'h000;
  localparam logic [CSR_ADDR_W-1:0] FUNCT12_MRET  = 12'h302;

  typedef enum logic [2:0] {
    OP_NONE    = 3'd0,
    OP_RW      = 3'd1,
    OP_RS      = 3'd2,
    OP_RC      = 3'd3,
    OP_ECALL   = 3'd4,
    OP_MRET    = 3'd5,
    OP_ILLEGAL = 3'd6
  } csr_op_e;

  // Register file index of each implemented CSR.
  typedef enum logic [1:0] {
    SEL_MSTATUS = 2'd0,
    SEL_MTVEC   = 2'd1,
    SEL_MEPC    = 2'd2,
    SEL_MCAUSE  = 2'd3
  } csr_sel_e;

  typedef struct packed {
    logic            valid;
    logic [31:0]     instr;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] pc;
  } csr_issue_t;

  typedef struct packed {
    logic            valid;
    csr_op_e         op;
    csr_sel_e        sel;
    logic [XLEN-1:0] operand;
    logic [4:0]      rd;
    logic [XLEN-1:0] pc;
  } csr_req_t;

  typedef struct packed {
    logic            take;
    logic            ret;
    logic [XLEN-1:0] epc;
    logic [XLEN-1:0] cause;
  } trap_upd_t;

  typedef struct packed {
    logic            valid;
    logic            rd_we;
    logic [4:0]      rd;
    logic [XLEN-1:0] rdata;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
  } csr_rsp_t;

endpackage

// File: tb_csr_unit.sv
// CSR unit directed testbench

module tb_csr_unit import rv_csr_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 40;
  // Instructions issued by reset, rmw, ecall, mret, illegal and stream tests.
  localparam int NUM_ISSUES = 5 + 48 + 6 + 6 + 6 + 40;

  logic            i_clk;
  logic            i_rst_n;
  csr_issue_t      i_issue;
  csr_rsp_t        o_rsp;
  logic [XLEN-1:0] model [4];
  csr_rsp_t        exp_q [$];
  int              cyc_q [$];
  int              cycle;
  int              seed;
  int              n_mismatch;
  int              n_protocol;
  logic [XLEN-1:0] last_rdata;
  csr_rsp_t        exp_rsp;
  int              exp_cycle;

  csr_unit_top dut0 (.i_clk(i_clk), .i_rst_n(i_rst_n), .i_issue(i_issue), .o_rsp(o_rsp));

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] enc_csr(logic [2:0] f3, logic [11:0] addr, logic [4:0] rs1,
                                          logic [4:0] rd);
    return {addr, rs1, f3, rd, OPC_SYSTEM};
  endfunction

  function automatic logic [11:0] addr_of(csr_sel_e sel);
    case (sel)
      SEL_MSTATUS: return 12'h300;
      SEL_MTVEC:   return 12'h305;
      SEL_MEPC:    return 12'h341;
      default:     return 12'h342;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic check_data(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h got %h", name, exp, act);
      n_mismatch++;
    end
  endtask

  task automatic check_rsp(csr_rsp_t exp, csr_rsp_t act);
    check_data("rsp.rd_we", 64'(exp.rd_we), 64'(act.rd_we));
    check_data("rsp.redirect", 64'(exp.redirect), 64'(act.redirect));
    if (exp.rd_we) begin
      check_data("rsp.rd", 64'(exp.rd), 64'(act.rd));
      check_data("rsp.rdata", exp.rdata, act.rdata);
    end
    if (exp.redirect) begin
      check_data("rsp.redirect_pc", exp.redirect_pc, act.redirect_pc);
    end
  endtask

  task automatic drive(logic [31:0] instr, logic [XLEN-1:0] rs1, logic [XLEN-1:0] pc,
                       csr_rsp_t exp);
    @(negedge i_clk);
    i_issue = '{valid: 1'b1, instr: instr, rs1_val: rs1, pc: pc};
    exp_q.push_back(exp);
    cyc_q.push_back(cycle);
  endtask

  task automatic csr_op(logic [2:0] f3, csr_sel_e sel, logic [XLEN-1:0] val);
    logic [XLEN-1:0] operand;
    logic [XLEN-1:0] nv;
    csr_rsp_t        exp;
    operand = f3[2] ? XLEN'(val[4:0]) : val;
    case (f3[1:0])
      2'd1:    nv = operand;
      2'd2:    nv = model[sel] | operand;
      default: nv = model[sel] & ~operand;
    endcase
    exp = '{valid: 1'b1, rd_we: 1'b1, rd: {3'b010, sel}, rdata: model[sel], redirect: 1'b0,
            redirect_pc: '0};
    // Set and clear with a zero operand leave the CSR alone.
    if (f3[1:0] == 2'd1 || operand != '0) begin
      model[sel] = (sel == SEL_MEPC) ? {nv[XLEN-1:2], 2'b00} : nv;
    end
    drive(enc_csr(f3, addr_of(sel), f3[2] ? val[4:0] : 5'd1, {3'b010, sel}), val, 64'h100, exp);
  endtask

  task automatic trap_op(logic [31:0] instr, logic [XLEN-1:0] pc, logic [XLEN-1:0] cause,
                         logic is_ret);
    csr_rsp_t exp;
    exp = '{valid: 1'b1, rd_we: 1'b0, rd: '0, rdata: '0, redirect: 1'b1, redirect_pc: '0};
    if (is_ret) begin
      exp.redirect_pc = model[SEL_MEPC];
      model[SEL_MSTATUS][3] = model[SEL_MSTATUS][7];
      model[SEL_MSTATUS][7] = 1'b1;
    end else begin
      exp.redirect_pc = {model[SEL_MTVEC][XLEN-1:2], 2'b00};
      model[SEL_MEPC] = {pc[XLEN-1:2], 2'b00};
      model[SEL_MCAUSE] = cause;
      model[SEL_MSTATUS][7] = model[SEL_MSTATUS][3];
      model[SEL_MSTATUS][3] = 1'b0;
    end
    drive(instr, rand64(), pc, exp);
  endtask

  task automatic drain();
    @(negedge i_clk);
    i_issue = '0;
    while (exp_q.size() != 0) begin
      @(negedge i_clk);
    end
  endtask

  task automatic read_back(csr_sel_e sel);
    csr_op(3'd2, sel, '0);
    drain();
  endtask

  task automatic test_reset();
    read_back(SEL_MSTATUS);
    check_data("mstatus", 64'h0000_000a_0000_1800, last_rdata);
    read_back(SEL_MTVEC);
    check_data("mtvec", '0, last_rdata);
    read_back(SEL_MEPC);
    check_data("mepc", '0, last_rdata);
    read_back(SEL_MCAUSE);
    check_data("mcause", '0, last_rdata);
    read_back(SEL_MSTATUS);
    check_data("mstatus", 64'h0000_000a_0000_1800, last_rdata);
  endtask

  task automatic test_rmw();
    logic [2:0] f3s [6] = '{3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7};
    for (int s = 0; s < 4; s++) begin
      for (int f = 0; f < 6; f++) begin
        csr_op(f3s[f], csr_sel_e'(s), rand64());
        read_back(csr_sel_e'(s));
        check_data("csr readback", model[s], last_rdata);
      end
    end
  endtask

  task automatic test_ecall();
    csr_op(3'd1, SEL_MTVEC, 64'h0000_0000_8000_0103);
    // Immediate 8 sets MIE.
    csr_op(3'd6, SEL_MSTATUS, 64'd8);
    trap_op(enc_csr(3'd0, 12'h000, 5'd0, 5'd0), 64'h1000, 64'd11, 1'b0);
    read_back(SEL_MEPC);
    check_data("mepc", 64'h1000, last_rdata);
    read_back(SEL_MCAUSE);
    check_data("mcause", 64'd11, last_rdata);
    read_back(SEL_MSTATUS);
    check_data("mstatus.MIE", '0, 64'(last_rdata[3]));
    check_data("mstatus.MPIE", 64'd1, 64'(last_rdata[7]));
  endtask

  task automatic test_mret();
    csr_op(3'd1, SEL_MEPC, 64'h2004);
    csr_op(3'd3, SEL_MSTATUS, 64'h80);
    trap_op(enc_csr(3'd0, 12'h302, 5'd0, 5'd0), 64'h1800, '0, 1'b1);
    read_back(SEL_MSTATUS);
    check_data("mstatus.MIE", '0, 64'(last_rdata[3]));
    check_data("mstatus.MPIE", 64'd1, 64'(last_rdata[7]));
    trap_op(enc_csr(3'd0, 12'h302, 5'd0, 5'd0), 64'h1804, '0, 1'b1);
    read_back(SEL_MSTATUS);
    check_data("mstatus.MIE", 64'd1, 64'(last_rdata[3]));
  endtask

  task automatic test_illegal();
    csr_op(3'd1, SEL_MTVEC, 64'h4000);
    trap_op(enc_csr(3'd1, 12'h7c0, 5'd1, 5'd3), 64'h3000, 64'd2, 1'b0);
    read_back(SEL_MCAUSE);
    check_data("mcause", 64'd2, last_rdata);
    read_back(SEL_MEPC);
    check_data("mepc", 64'h3000, last_rdata);
    // funct3 4 is no CSR op, even with a valid address.
    trap_op(enc_csr(3'd4, 12'h305, 5'd1, 5'd3), 64'h3100, 64'd2, 1'b0);
    read_back(SEL_MTVEC);
    check_data("mtvec", 64'h4000, last_rdata);
  endtask

  task automatic test_stream();
    logic [31:0] r;
    for (int i = 0; i < 20; i++) begin
      r = $random(seed);
      csr_op(3'd1, csr_sel_e'(r[1:0]), rand64());
      csr_op(3'd2, csr_sel_e'(r[1:0]), '0);
    end
    drain();
  endtask

  // Responses are sampled on the falling edge, two cycles after their issue.
  always @(negedge i_clk) begin
    if (i_rst_n && o_rsp.valid) begin
      if (exp_q.size() == 0) begin
        $display("Response arrived with no instruction outstanding at cycle %0d", cycle);
        n_protocol++;
      end else begin
        exp_rsp   = exp_q.pop_front();
        exp_cycle = cyc_q.pop_front();
        check_rsp(exp_rsp, o_rsp);
        if (cycle != exp_cycle + 2) begin
          $display("Response for cycle %0d issue arrived at cycle %0d", exp_cycle, cycle);
          n_protocol++;
        end
        last_rdata = o_rsp.rdata;
      end
    end
  end

  initial begin
    #((NUM_ISSUES * 4 + 200 + 3) * CLK_PERIOD);
    $display("Timeout at cycle %0d, the DUT stopped responding", cycle);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    seed       = 32'h00488532;
    n_mismatch = 0;
    n_protocol = 0;
    cycle      = 0;
    model      = '{64'h0000_000a_0000_1800, '0, '0, '0};
    i_issue    = '0;
    i_rst_n    = 1'b0;
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;
    test_reset();
    test_rmw();
    test_ecall();
    test_mret();
    test_illegal();
    test_stream();
    repeat (4) @(negedge i_clk);
    if (exp_q.size() != 0) begin
      $display("%0d expected responses never arrived", exp_q.size());
      n_protocol++;
    end
    $display("Errors: %0d mismatches, %0d protocol", n_mismatch, n_protocol);
    if (n_mismatch + n_protocol == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: trap_unit.sv
// Trap and return control

module trap_unit import rv_csr_pkg::*; (
  input  csr_req_t        i_req,
  input  logic [XLEN-1:0] i_mtvec,
  input  logic [XLEN-1:0] i_mepc,
  output trap_upd_t       o_trap,
  output logic            o_redirect,
  output logic [XLEN-1:0] o_redirect_pc
);

  logic            take;
  logic            ret;
  logic [XLEN-1:0] cause;
  logic [XLEN-1:0] trap_base;

  // The mode bits are ignored in direct mode.
  assign trap_base = {i_mtvec[XLEN-1:2], 2'b00};

  always_comb begin
    take  = 1'b0;
    ret   = 1'b0;
    cause = CAUSE_ILLEGAL;
    if (i_req.valid) begin
      case (i_req.op)
        OP_ECALL: begin
          take  = 1'b1;
          cause = CAUSE_ECALL_M;
        end
        OP_ILLEGAL: begin
          take  = 1'b1;
          cause = CAUSE_ILLEGAL;
        end
        OP_MRET: begin
          ret = 1'b1;
        end
        default: begin
          take = 1'b0;
          ret  = 1'b0;
        end
      endcase
    end
  end

  always_comb begin
    o_trap.take  = take;
    o_trap.ret   = ret;
    o_trap.epc   = i_req.pc;
    o_trap.cause = cause;
  end

  assign o_redirect    = take | ret;
  // Mret returns through mepc.
  assign o_redirect_pc = ret ? i_mepc : trap_base;

endmodule

// File: verilog.f
rv_csr_pkg.sv
csr_decode.sv
trap_unit.sv
csr_regfile.sv
csr_unit_top.sv
csr_unit_sva.sv
tb_csr_unit.sv
